// ==== files.f ====
hdl/obi_pkg.sv
hdl/obi_addr_decoder.sv
hdl/obi_outstanding_fifo.sv
hdl/obi_data_adapter.sv
hdl/obi_alert_collector.sv
hdl/obi_data_subsystem.sv
test/obi_data_tb.sv

// ==== hdl/obi_addr_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI address decoder
// Routes one transaction stream to a port picked by address bits and
// returns the grant of that port as ready
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_addr_decoder #(
  parameter int unsigned NUM_PORTS = 2
) (
  input  logic                 trans_valid_i,
  input  obi_pkg::obi_trans_t  trans_i,
  output logic                 trans_ready_o,
  output logic [NUM_PORTS-1:0] port_valid_o,
  output obi_pkg::obi_trans_t  port_trans_o,
  input  logic [NUM_PORTS-1:0] port_ready_i
);

  import obi_pkg::*;

  // Select field width, at least one bit so the slice stays legal
  localparam int unsigned SEL_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  logic [SEL_W-1:0] sel;
  logic             sel_in_range;

  // Single port builds route everything to port 0
  assign sel          = (NUM_PORTS > 1) ? trans_i.addr[PORT_SEL_LSB +: SEL_W] : '0;
  assign sel_in_range = (sel < NUM_PORTS);

  // Payload fans out to every port, only valid is steered
  assign port_trans_o = trans_i;

  always_comb begin
    port_valid_o  = '0;
    trans_ready_o = 1'b0;
    // Indices past NUM_PORTS only exist for non power of two counts
    if (sel_in_range) begin
      port_valid_o[sel] = trans_valid_i;
      trans_ready_o     = port_ready_i[sel];
    end
  end

  // At most one adapter sees a request at any time
  always_comb begin
    a_valid_onehot: assert ($onehot0(port_valid_o))
      else $error("decoder drove more than one port valid");
  end

endmodule

`default_nettype wire

// ==== hdl/obi_alert_collector.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI alert collector
// Folds the error strobes of all ports into sticky major and protocol
// alert levels, cleared only by reset
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_alert_collector #(
  parameter int unsigned NUM_PORTS = 2
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic [NUM_PORTS-1:0] integrity_err_i,
  input  logic [NUM_PORTS-1:0] protocol_err_i,
  output logic                 alert_major_o,
  output logic                 alert_protocol_o
);

  logic alert_major_q;
  logic alert_protocol_q;
  logic any_integrity_err;
  logic any_protocol_err;

  // Any port error counts
  assign any_integrity_err = |integrity_err_i;
  assign any_protocol_err  = |protocol_err_i;

  // Sticky levels, one cycle after the first error
  always_ff @(posedge clk) begin
    if (reset_i) begin
      alert_major_q    <= 1'b0;
      alert_protocol_q <= 1'b0;
    end else begin
      if (any_integrity_err) begin
        alert_major_q <= 1'b1;
      end
      if (any_protocol_err) begin
        alert_protocol_q <= 1'b1;
      end
    end
  end

  assign alert_major_o    = alert_major_q;
  assign alert_protocol_o = alert_protocol_q;

endmodule

`default_nettype wire

// ==== hdl/obi_data_adapter.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI data adapter
// Drives one OBI A channel with check bits, passes the R channel back as
// a response and checks grant, rvalid and response integrity
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_data_adapter #(
  parameter int unsigned MAX_OUTSTANDING = 2,
  parameter bit          SECURE          = 1'b1
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 trans_valid_i,
  input  obi_pkg::obi_trans_t  trans_i,
  output logic                 trans_ready_o,
  output obi_pkg::obi_a_chan_t obi_a_chan_o,
  input  obi_pkg::obi_a_resp_t obi_a_resp_i,
  input  obi_pkg::obi_r_chan_t obi_r_chan_i,
  output logic                 resp_valid_o,
  output obi_pkg::obi_resp_t   resp_o,
  output logic                 integrity_err_o,
  output logic                 protocol_err_o
);

  import obi_pkg::*;

  logic              full;
  logic              req;
  logic              gntpar_err;
  logic              gntpar_err_resp;
  logic              integrity_resp;
  logic              fifo_protocol_err;
  logic              resp_integrity_err;
  logic [RCHK_W-1:0] rchk_exp;

  ////////////////////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////////////////////

  // Request held back while MAX_OUTSTANDING transactions are in flight
  assign req           = trans_valid_i && !full;
  assign trans_ready_o = obi_a_resp_i.gnt && !full;

  always_comb begin
    obi_a_chan_o.req    = req;
    obi_a_chan_o.reqpar = !req;
    obi_a_chan_o.trans  = trans_i;
    // Byte parities even, control groups odd
    obi_a_chan_o.achk   = {^trans_i.wdata[31:24], ^trans_i.wdata[23:16],
                           ^trans_i.wdata[15:8], ^trans_i.wdata[7:0],
                           ~^{trans_i.be, trans_i.we},
                           ~^trans_i.prot,
                           ^trans_i.addr[31:24], ^trans_i.addr[23:16],
                           ^trans_i.addr[15:8], ^trans_i.addr[7:0]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////////////////////

  assign resp_valid_o = obi_r_chan_i.rvalid;

  // Expected rchk from the returned word
  assign rchk_exp = {^obi_r_chan_i.rdata[31:24], ^obi_r_chan_i.rdata[23:16],
                     ^obi_r_chan_i.rdata[15:8], ^obi_r_chan_i.rdata[7:0],
                     ~obi_r_chan_i.err};

  always_comb begin
    resp_o.rdata         = obi_r_chan_i.rdata;
    resp_o.err           = obi_r_chan_i.err;
    resp_o.integrity     = SECURE ? integrity_resp : 1'b0;
    resp_o.integrity_err = resp_integrity_err;
  end

  // Outstanding tracking is kept in every build for the in-flight limit
  obi_outstanding_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_fifo (
    .clk               (clk),
    .reset_i           (reset_i),
    .push_i            (req && obi_a_resp_i.gnt),
    .gntpar_err_i      (gntpar_err),
    .integrity_i       (trans_i.integrity),
    .we_i              (trans_i.we),
    .pop_i             (obi_r_chan_i.rvalid),
    .full_o            (full),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .protocol_err_o    (fifo_protocol_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Integrity checks
  ////////////////////////////////////////////////////////////////////////////

  if (SECURE) begin : g_secure
    logic rvalidpar_err;
    logic rchk_err;

    // Parity lines are the inverse of their strobe, checked every cycle
    assign gntpar_err    = (obi_a_resp_i.gnt == obi_a_resp_i.gntpar);
    assign rvalidpar_err = (obi_r_chan_i.rvalid == obi_r_chan_i.rvalidpar);

    // rchk only checked when the requester asked for it
    assign rchk_err = integrity_resp && (obi_r_chan_i.rchk != rchk_exp);

    assign resp_integrity_err = rvalidpar_err ||
                                (obi_r_chan_i.rvalid && (gntpar_err_resp || rchk_err));
    assign integrity_err_o    = resp_integrity_err || gntpar_err;
    assign protocol_err_o     = fifo_protocol_err;
  end else begin : g_no_secure
    assign gntpar_err         = 1'b0;
    assign resp_integrity_err = 1'b0;
    assign integrity_err_o    = 1'b0;
    assign protocol_err_o     = 1'b0;
  end

  // OBI rule, an ungranted request keeps req and payload until its transfer
  a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
    req && !obi_a_resp_i.gnt |=> req && $stable(obi_a_chan_o.trans))
    else $error("OBI request changed before grant");

endmodule

`default_nettype wire

// ==== hdl/obi_data_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI data subsystem
// Address decoder, one data adapter per port and the alert collector
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_data_subsystem #(
  parameter int unsigned NUM_PORTS       = 2,
  parameter int unsigned MAX_OUTSTANDING = 2,
  parameter bit          SECURE          = 1'b1
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 trans_valid_i,
  input  obi_pkg::obi_trans_t  trans_i,
  output logic                 trans_ready_o,
  output obi_pkg::obi_a_chan_t obi_a_chan_o [NUM_PORTS],
  input  obi_pkg::obi_a_resp_t obi_a_resp_i [NUM_PORTS],
  input  obi_pkg::obi_r_chan_t obi_r_chan_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0] resp_valid_o,
  output obi_pkg::obi_resp_t   resp_o [NUM_PORTS],
  output logic                 alert_major_o,
  output logic                 alert_protocol_o
);

  import obi_pkg::*;

  logic [NUM_PORTS-1:0] port_valid;
  logic [NUM_PORTS-1:0] port_ready;
  logic [NUM_PORTS-1:0] integrity_err;
  logic [NUM_PORTS-1:0] protocol_err;
  obi_trans_t           port_trans;

  // Port select from address bits
  obi_addr_decoder #(
    .NUM_PORTS (NUM_PORTS)
  ) u_decoder (
    .trans_valid_i (trans_valid_i),
    .trans_i       (trans_i),
    .trans_ready_o (trans_ready_o),
    .port_valid_o  (port_valid),
    .port_trans_o  (port_trans),
    .port_ready_i  (port_ready)
  );

  // One adapter per OBI port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    obi_data_adapter #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING),
      .SECURE          (SECURE)
    ) u_adapter (
      .clk             (clk),
      .reset_i         (reset_i),
      .trans_valid_i   (port_valid[p]),
      .trans_i         (port_trans),
      .trans_ready_o   (port_ready[p]),
      .obi_a_chan_o    (obi_a_chan_o[p]),
      .obi_a_resp_i    (obi_a_resp_i[p]),
      .obi_r_chan_i    (obi_r_chan_i[p]),
      .resp_valid_o    (resp_valid_o[p]),
      .resp_o          (resp_o[p]),
      .integrity_err_o (integrity_err[p]),
      .protocol_err_o  (protocol_err[p])
    );
  end

  obi_alert_collector #(
    .NUM_PORTS (NUM_PORTS)
  ) u_alerts (
    .clk              (clk),
    .reset_i          (reset_i),
    .integrity_err_i  (integrity_err),
    .protocol_err_i   (protocol_err),
    .alert_major_o    (alert_major_o),
    .alert_protocol_o (alert_protocol_o)
  );

endmodule

`default_nettype wire

// ==== hdl/obi_outstanding_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI outstanding transaction FIFO
// Stores per-transaction attributes when granted, hands them back in order
// when the response arrives, and flags responses with nothing pending
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_outstanding_fifo #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic clk,
  input  logic reset_i,
  input  logic push_i,
  input  logic gntpar_err_i,
  input  logic integrity_i,
  input  logic we_i,
  input  logic pop_i,
  output logic full_o,
  output logic gntpar_err_resp_o,
  output logic integrity_resp_o,
  output logic protocol_err_o
);

  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // One entry per granted transaction
  typedef struct packed {
    logic gntpar_err;
    logic integrity;
    logic we;
  } entry_t;

  entry_t           mem_q [MAX_OUTSTANDING];
  entry_t           head;
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty;
  logic             pop_ok;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CNT_W'(MAX_OUTSTANDING));
  assign head   = mem_q[rptr_q];

  // A response with no transaction pending is a protocol error and is dropped
  assign pop_ok         = pop_i && !empty;
  assign protocol_err_o = pop_i && empty;

  // Head attributes, masked while empty
  assign gntpar_err_resp_o = !empty && head.gntpar_err;
  assign integrity_resp_o  = !empty && head.integrity;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= ptr_next(wptr_q);
      end
      if (pop_ok) begin
        rptr_q <= ptr_next(rptr_q);
      end
      // Push and pop together leave the count unchanged
      case ({push_i, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wptr_q] <= '{gntpar_err: gntpar_err_i, integrity: integrity_i, we: we_i};
    end
  end

  // Adapter holds req low while full
  a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
    push_i |-> !full_o)
    else $error("push into full outstanding FIFO");

  // Every popped entry was written by an earlier push
  a_head_written: assert property (@(posedge clk) disable iff (reset_i)
    pop_ok |-> !$isunknown(head))
    else $error("pop of an entry that was never written");

endmodule

`default_nettype wire

// ==== hdl/obi_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI data port package
// Shared widths and the request, response and bus channel structs used by
// the data-side OBI adapters, decoder and subsystem top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package obi_pkg;

  // Address and data word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned PROT_W = 3;

  // Address phase check bits, MSB first
  //   [9:6] even parity of wdata bytes 3..0
  //   [5]   odd parity of {be, we}
  //   [4]   odd parity of prot
  //   [3:0] even parity of addr bytes 3..0
  // Atomics, message ID and debug are not carried, so their terms drop out
  localparam int unsigned ACHK_W = 10;

  // Response check bits, MSB first
  //   [4:1] even parity of rdata bytes 3..0
  //   [0]   odd parity of err
  localparam int unsigned RCHK_W = 5;

  // Lowest address bit of the port select field
  localparam int unsigned PORT_SEL_LSB = 12;

  // Transaction request from the load/store side
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [PROT_W-1:0] prot;
    // Requester wants response checking
    logic              integrity;
  } obi_trans_t;

  // OBI A channel toward a slave
  typedef struct packed {
    logic              req;
    logic              reqpar;
    obi_trans_t        trans;
    logic [ACHK_W-1:0] achk;
  } obi_a_chan_t;

  // Grant side of the A channel
  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_a_resp_t;

  // OBI R channel from a slave
  typedef struct packed {
    logic              rvalid;
    logic              rvalidpar;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
  } obi_r_chan_t;

  // Response toward the requester, consumer always ready
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              integrity;
    logic              integrity_err;
  } obi_resp_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the OBI data subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f run.log

verilator --binary --timing --assert -Wno-fatal --top-module obi_data_tb \
  -f files.f > build.log 2>&1 \
  && ./obj_dir/Vobi_data_tb > run.log 2>&1 \
  || echo "Build or simulation did not complete, see build.log and run.log"

grep -q "Everything OK" run.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/obi_data_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI data subsystem testbench
// Applies a table of load/store rows to the DUT and plays one OBI slave
// per port, including parity faults, a spurious rvalid and back-pressure
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module obi_data_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import obi_pkg::*;

  localparam int NUM_PORTS = 2;
  localparam int MAX_OUT   = 2;
  localparam int NROWS     = 9;
  localparam int LIMIT     = NROWS * 20 + 200;

  // Fault bits of a row
  localparam int F_GNTPAR    = 3;
  localparam int F_RVALIDPAR = 2;
  localparam int F_RCHK      = 1;
  localparam int F_SPURIOUS  = 0;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic        integrity;
    logic [2:0]  gnt_delay;
    logic [3:0]  fault;
    logic        exp_port;
    logic        exp_ierr;
    logic        exp_palert;
  } row_t;

  // addr, we, wdata, integrity, grant delay, faults, port, integrity_err, protocol alert
  localparam row_t ROWS [NROWS] = '{
    '{32'h0000_0040, 1'b0, 32'h0000_0000, 1'b1, 3'd0, 4'b0000, 1'b0, 1'b0, 1'b0},
    '{32'h0000_1a24, 1'b1, 32'hcafe_f00d, 1'b1, 3'd2, 4'b0000, 1'b1, 1'b0, 1'b0},
    '{32'h0000_3008, 1'b0, 32'h0000_0000, 1'b0, 3'd1, 4'b0000, 1'b1, 1'b0, 1'b0},
    '{32'h8000_2ffc, 1'b1, 32'h1234_5678, 1'b1, 3'd3, 4'b0000, 1'b0, 1'b0, 1'b0},
    // Bad rchk ignored without integrity
    '{32'h0000_1100, 1'b0, 32'h0000_0000, 1'b0, 3'd0, 4'b0010, 1'b1, 1'b0, 1'b0},
    '{32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0, 3'd0, 4'b0001, 1'b1, 1'b0, 1'b1},
    '{32'h0000_0200, 1'b1, 32'h0f0f_a5a5, 1'b0, 3'd1, 4'b1000, 1'b0, 1'b1, 1'b1},
    '{32'h0000_1300, 1'b0, 32'h0000_0000, 1'b1, 3'd0, 4'b0100, 1'b1, 1'b1, 1'b1},
    '{32'h0000_0500, 1'b0, 32'h0000_0000, 1'b1, 3'd2, 4'b0010, 1'b0, 1'b1, 1'b1}
  };

  string row_names [NROWS] = '{"rd_p0_clean", "wr_p1_clean", "rd_p1_noint", "wr_p0_delay",
                               "rchk_noint", "spurious_p1", "bad_gntpar", "bad_rvalidpar",
                               "bad_rchk"};

  logic                 clk;
  logic                 reset;
  logic                 trans_valid;
  obi_trans_t           trans;
  logic                 trans_ready;
  obi_a_chan_t          a_chan [NUM_PORTS];
  obi_a_resp_t          a_resp [NUM_PORTS];
  obi_r_chan_t          r_chan [NUM_PORTS];
  logic [NUM_PORTS-1:0] resp_valid;
  obi_resp_t            resp [NUM_PORTS];
  logic                 alert_major;
  logic                 alert_protocol;

  int          errors    = 0;
  int          cycles    = 0;
  logic        major_exp = 1'b0;
  logic        prot_exp  = 1'b0;
  logic [31:0] lfsr      = 32'h64af_73fa;

  obi_data_subsystem UUT (
    .clk              (clk),
    .reset_i          (reset),
    .trans_valid_i    (trans_valid),
    .trans_i          (trans),
    .trans_ready_o    (trans_ready),
    .obi_a_chan_o     (a_chan),
    .obi_a_resp_i     (a_resp),
    .obi_r_chan_i     (r_chan),
    .resp_valid_o     (resp_valid),
    .resp_o           (resp),
    .alert_major_o    (alert_major),
    .alert_protocol_o (alert_protocol)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Even byte parities and odd parity on the control groups
  function automatic logic [ACHK_W-1:0] achk_of(input obi_trans_t t);
    logic [ACHK_W-1:0] c;
    for (int b = 0; b < 4; b++) begin
      c[6+b] = ^t.wdata[8*b +: 8];
      c[b]   = ^t.addr[8*b +: 8];
    end
    c[5] = ~(^{t.be, t.we});
    c[4] = ~(^t.prot);
    return c;
  endfunction

  function automatic logic [RCHK_W-1:0] rchk_of(input logic [31:0] d, input logic e);
    logic [RCHK_W-1:0] c;
    for (int b = 0; b < 4; b++) begin
      c[1+b] = ^d[8*b +: 8];
    end
    c[0] = ~e;
    return c;
  endfunction

  function automatic obi_trans_t make_trans(input logic [31:0] addr, input logic we,
                                            input logic [31:0] wdata, input logic integ);
    obi_trans_t t;
    t.addr      = addr;
    t.we        = we;
    t.be        = 4'hf;
    t.wdata     = wdata;
    t.prot      = 3'b011;
    t.integrity = integ;
    return t;
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [127:0] exp, input logic [127:0] act);
    errors++;
    $display("mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
  endtask

  // Inputs move 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic idle_bus();
    for (int p = 0; p < NUM_PORTS; p++) begin
      a_resp[p] = '{gnt: 1'b0, gntpar: 1'b1};
      r_chan[p] = '{rvalid: 1'b0, rvalidpar: 1'b1, rdata: '0, err: 1'b0, rchk: '0};
    end
  endtask

  task automatic check_routing(input string name, input int port, input obi_trans_t t);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (p == port) begin
        if (a_chan[p].req !== 1'b1) report_mismatch(name, "req", 1, a_chan[p].req);
        if (a_chan[p].reqpar !== 1'b0) report_mismatch(name, "reqpar", 0, a_chan[p].reqpar);
        if (a_chan[p].trans !== t) report_mismatch(name, "payload", t, a_chan[p].trans);
        if (a_chan[p].achk !== achk_of(t)) begin
          report_mismatch(name, "achk", achk_of(t), a_chan[p].achk);
        end
      end else if (a_chan[p].req !== 1'b0) begin
        report_mismatch(name, "req on unselected port", 0, a_chan[p].req);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Slave model and sequences
  ////////////////////////////////////////////////////////////////////////////

  // One response beat on port p checked mid-cycle
  task automatic give_response(input string name, input int p, input logic bad_rvp,
                               input logic bad_rchk, input logic exp_integ,
                               input logic exp_ierr);
    logic [31:0] d;
    logic [31:0] e;
    take_bits(32, d);
    take_bits(1, e);
    r_chan[p].rvalid    = 1'b1;
    r_chan[p].rvalidpar = bad_rvp;
    r_chan[p].rdata     = d;
    r_chan[p].err       = e[0];
    r_chan[p].rchk      = rchk_of(d, e[0]) ^ {3'b000, bad_rchk, 1'b0};
    #40;
    if (resp_valid !== (1 << p)) report_mismatch(name, "resp_valid_o", 1 << p, resp_valid);
    if (resp[p].rdata !== d) report_mismatch(name, "rdata", d, resp[p].rdata);
    if (resp[p].err !== e[0]) report_mismatch(name, "err", e[0], resp[p].err);
    // Integrity flag of the transaction this beat answers
    if (resp[p].integrity !== exp_integ) begin
      report_mismatch(name, "integrity", exp_integ, resp[p].integrity);
    end
    if (resp[p].integrity_err !== exp_ierr) begin
      report_mismatch(name, "integrity_err", exp_ierr, resp[p].integrity_err);
    end
    next_cycle();
    r_chan[p] = '{rvalid: 1'b0, rvalidpar: 1'b1, rdata: '0, err: 1'b0, rchk: '0};
  endtask

  task automatic run_row(input row_t r, input string name);
    obi_trans_t t;
    int         p;
    p = int'(r.exp_port);
    t = make_trans(r.addr, r.we, r.wdata, r.integrity);
    if (!r.fault[F_SPURIOUS]) begin
      trans       = t;
      trans_valid = 1'b1;
      // Slave stalls for the row's grant delay
      for (int d = 0; d < int'(r.gnt_delay); d++) begin
        #40;
        check_routing(name, p, t);
        if (trans_ready !== 1'b0) report_mismatch(name, "ready before grant", 0, trans_ready);
        next_cycle();
      end
      a_resp[p] = '{gnt: 1'b1, gntpar: r.fault[F_GNTPAR]};
      #40;
      check_routing(name, p, t);
      if (trans_ready !== 1'b1) report_mismatch(name, "ready at grant", 1, trans_ready);
      next_cycle();
      trans_valid = 1'b0;
      a_resp[p]   = '{gnt: 1'b0, gntpar: 1'b1};
    end
    // A spurious beat answers no request, so no integrity is asked for
    give_response(name, p, r.fault[F_RVALIDPAR], r.fault[F_RCHK],
                  r.integrity && !r.fault[F_SPURIOUS], r.exp_ierr);
    // Alerts are sticky and one cycle late
    major_exp = major_exp | r.exp_ierr;
    prot_exp  = prot_exp | r.exp_palert;
    #40;
    if (alert_major !== major_exp) report_mismatch(name, "alert_major", major_exp, alert_major);
    if (alert_protocol !== prot_exp) begin
      report_mismatch(name, "alert_protocol", prot_exp, alert_protocol);
    end
    next_cycle();
  endtask

  // MAX_OUT + 1 requests to port 0 with responses held back
  task automatic run_backpressure();
    obi_trans_t t;
    int         n;
    a_resp[0] = '{gnt: 1'b1, gntpar: 1'b0};
    for (int k = 0; k <= MAX_OUT; k++) begin
      t           = make_trans(32'h0000_0100 + 32'(k * 4), 1'b1, 32'h5a5a_0000 + 32'(k), 1'b1);
      trans       = t;
      trans_valid = 1'b1;
      #40;
      if (k < MAX_OUT && trans_ready !== 1'b1) begin
        report_mismatch("backpressure", "ready below limit", 1, trans_ready);
      end
      if (k == MAX_OUT && (trans_ready !== 1'b0 || a_chan[0].req !== 1'b0)) begin
        report_mismatch("backpressure", "ready and req while full", 0,
                        {trans_ready, a_chan[0].req});
      end
      next_cycle();
    end
    give_response("backpressure", 0, 1'b0, 1'b0, 1'b1, 1'b0);
    // Held request goes out once a slot frees
    n = 0;
    #40;
    while (trans_ready !== 1'b1 && n < 8) begin
      next_cycle();
      #40;
      n++;
    end
    if (trans_ready !== 1'b1) begin
      errors++;
      $display("Held request was never granted after a response returned");
    end
    check_routing("backpressure", 0, t);
    next_cycle();
    trans_valid = 1'b0;
    a_resp[0]   = '{gnt: 1'b0, gntpar: 1'b1};
    for (int k = 0; k < MAX_OUT; k++) begin
      give_response("backpressure", 0, 1'b0, 1'b0, 1'b1, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    trans_valid = 1'b0;
    trans       = '0;
    idle_bus();
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    for (int i = 0; i < NROWS; i++) begin
      run_row(ROWS[i], row_names[i]);
    end
    run_backpressure();
    $display("Summary: %0d table rows plus back-pressure, %0d errors", NROWS, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
